// ==== hdl/dcache_pkg.sv ====
// Shared word width, controller state enum and Wishbone cycle type enum for the data cache

package dcache_pkg;

        // ----------------------------------------
        // Word constants
        // ----------------------------------------

        localparam int word_w = 32;             // Processor word and bus data width

        // ----------------------------------------
        // Controller states
        // ----------------------------------------

        typedef enum logic [2:0] {
                IDLE      = 3'd0,               // Lookup, hits served here
                EVICT     = 3'd1,               // Dirty victim going out
                FILL      = 3'd2,               // Line coming in
                UPDATE    = 3'd3,               // Write fetched line, ack
                UNC_ISSUE = 3'd4,               // Single beat in flight
                UNC_WAIT  = 3'd5                // Ack of the single beat
        } ctrl_state_t;

        // ----------------------------------------
        // Wishbone cycle type identifiers
        // ----------------------------------------

        typedef enum logic [2:0] {
                CTI_CLASSIC = 3'd0,
                CTI_BURST   = 3'd2,             // Incrementing burst
                CTI_EOB     = 3'd7              // Last beat of a burst
        } cti_t;

endpackage

// ==== hdl/line_xfer_if.sv ====
// Line transfer command and data interface between cache controller and bus master
`timescale 1ns/1ps

interface line_xfer_if
        import dcache_pkg::*;
#(
        parameter int LINE_BYTES = 16
)
();
        logic                    start;         // One cycle command strobe
        logic                    write;
        logic                    single;        // One beat, classic cycle
        logic [word_w-1:0]       addr;
        logic [3:0]              sel;           // Lanes of a single beat
        logic [LINE_BYTES*8-1:0] wline;         // Held until done
        logic                    done;          // One cycle completion pulse
        logic [LINE_BYTES*8-1:0] rline;

        modport ctrl   (output start, write, single, addr, sel, wline,
                        input  done, rline);

        modport master (input  start, write, single, addr, sel, wline,
                        output done, rline);

endinterface

// ==== hdl/dcache_store.sv ====
// Flop based tag, valid, dirty and line data arrays with byte enabled line write
`timescale 1ns/1ps

module dcache_store
        import dcache_pkg::*;
#(
        parameter int CACHE_BYTES = 1024,
        parameter int LINE_BYTES  = 16
)
(
        input  logic                                     i_clk,
        input  logic                                     i_reset,
        input  logic [$clog2(CACHE_BYTES/LINE_BYTES)-1:0] i_index,
        input  logic                                     i_wr_en,
        input  logic [word_w-$clog2(CACHE_BYTES)-1:0]    i_tag,
        input  logic                                     i_dirty,
        input  logic [LINE_BYTES*8-1:0]                  i_line,
        input  logic [LINE_BYTES-1:0]                    i_line_ben,
        output logic [word_w-$clog2(CACHE_BYTES)-1:0]    o_tag,
        output logic                                     o_valid,
        output logic                                     o_dirty,
        output logic [LINE_BYTES*8-1:0]                  o_line
);

localparam int LINES = CACHE_BYTES / LINE_BYTES;
localparam int TAG_W = word_w - $clog2(CACHE_BYTES);   // Index plus offset bits removed

logic [TAG_W-1:0]          tag_mem  [LINES];
logic [LINE_BYTES*8-1:0]   line_mem [LINES];
logic [LINES-1:0]          valid_q;
logic [LINES-1:0]          dirty_q;                    // Meaningless while invalid

// Valid bits, the only state cleared on reset
always_ff @(posedge i_clk)
begin
        if (i_reset)
                valid_q <= '0;
        else if (i_wr_en)
                valid_q[i_index] <= 1'b1;
end

// Tag, dirty and byte lanes of the line
always_ff @(posedge i_clk)
begin
        if (i_wr_en)
        begin
                tag_mem[i_index] <= i_tag;
                dirty_q[i_index] <= i_dirty;
                for (int b = 0; b < LINE_BYTES; b++)
                begin
                        if (i_line_ben[b])
                                line_mem[i_index][b*8 +: 8] <= i_line[b*8 +: 8];
                end
        end
end

// Asynchronous read port
assign o_tag   = tag_mem[i_index];
assign o_valid = valid_q[i_index];
assign o_dirty = dirty_q[i_index];
assign o_line  = line_mem[i_index];

endmodule

// ==== hdl/dcache_ctrl.sv ====
// Data cache FSM for lookup, line fill, dirty eviction and uncached single beats
`timescale 1ns/1ps

module dcache_ctrl
        import dcache_pkg::*;
#(
        parameter int CACHE_BYTES = 1024,
        parameter int LINE_BYTES  = 16
)
(
        input  logic                                      i_clk,
        input  logic                                      i_reset,
        // Processor side
        input  logic                                      i_rd,
        input  logic                                      i_wr,
        input  logic                                      i_uncached,
        input  logic [word_w-1:0]                         i_addr,
        input  logic [word_w-1:0]                         i_din,
        input  logic [3:0]                                i_ben,
        output logic                                      o_ack,
        output logic [word_w-1:0]                         o_dat,
        output ctrl_state_t                               o_state,
        // Store side
        output logic [$clog2(CACHE_BYTES/LINE_BYTES)-1:0] o_index,
        output logic                                      o_wr_en,
        output logic [word_w-$clog2(CACHE_BYTES)-1:0]     o_tag,
        output logic                                      o_dirty,
        output logic [LINE_BYTES*8-1:0]                   o_line,
        output logic [LINE_BYTES-1:0]                     o_line_ben,
        input  logic [word_w-$clog2(CACHE_BYTES)-1:0]     i_tag,
        input  logic                                      i_valid,
        input  logic                                      i_dirty,
        input  logic [LINE_BYTES*8-1:0]                   i_line,
        // Bus master
        line_xfer_if.ctrl                                 xfer
);

localparam int LINE_W = LINE_BYTES * 8;
localparam int WORDS  = LINE_BYTES / (word_w / 8);
localparam int OFF_W  = $clog2(LINE_BYTES);
localparam int IDX_W  = $clog2(CACHE_BYTES / LINE_BYTES);
localparam int TAG_W  = word_w - IDX_W - OFF_W;
localparam int WSEL_W = OFF_W - 2;

ctrl_state_t            state_q, state_d;
logic [word_w-1:0]      addr_q, din_q;          // Request held over a miss
logic [3:0]             ben_q;
logic                   wr_q;
logic [word_w-1:0]      cur_addr, cur_din;
logic [3:0]             cur_ben;
logic                   cur_wr;
logic [TAG_W-1:0]       cur_tag;
logic [IDX_W-1:0]       cur_idx;
logic [WSEL_W-1:0]      cur_word;
logic                   req, hit, unc, evict_now;
logic [LINE_W-1:0]      rep_din, merged;
logic [LINE_BYTES-1:0]  shift_ben;

// ----------------------------------------
// Request view
// ----------------------------------------

// Live inputs in IDLE, latched copy elsewhere
assign cur_addr = (state_q == IDLE) ? i_addr : addr_q;
assign cur_din  = (state_q == IDLE) ? i_din  : din_q;
assign cur_ben  = (state_q == IDLE) ? i_ben  : ben_q;
assign cur_wr   = (state_q == IDLE) ? i_wr   : wr_q;

assign cur_tag  = cur_addr[word_w-1 -: TAG_W];
assign cur_idx  = cur_addr[OFF_W +: IDX_W];
assign cur_word = cur_addr[2 +: WSEL_W];

assign req       = i_rd | i_wr;
assign hit       = i_valid && (i_tag == cur_tag);
assign rep_din   = {WORDS{cur_din}};
assign shift_ben = LINE_BYTES'(cur_ben) << {cur_word, 2'b00};

always_ff @(posedge i_clk)
begin
        if (state_q == IDLE)
        begin
                addr_q <= i_addr;
                din_q  <= i_din;
                ben_q  <= i_ben;
                wr_q   <= i_wr;
        end
end

// Processor bytes laid over the fetched line
always_comb
begin
        for (int b = 0; b < LINE_BYTES; b++)
        begin
                if (cur_wr && shift_ben[b])
                        merged[b*8 +: 8] = rep_din[b*8 +: 8];
                else
                        merged[b*8 +: 8] = xfer.rline[b*8 +: 8];
        end
end

// ----------------------------------------
// State machine
// ----------------------------------------

always_ff @(posedge i_clk)
begin
        if (i_reset)
                state_q <= IDLE;
        else
                state_q <= state_d;
end

always_comb
begin
        state_d    = state_q;
        o_ack      = 1'b0;
        o_wr_en    = 1'b0;
        xfer.start = 1'b0;

        case (state_q)
        IDLE:
        begin
                if (req && i_uncached)
                begin
                        xfer.start = 1'b1;
                        state_d    = UNC_ISSUE;
                end
                else if (req && hit)
                begin
                        o_ack   = 1'b1;         // Zero latency hit
                        o_wr_en = i_wr;
                end
                else if (req)
                begin
                        xfer.start = 1'b1;
                        state_d    = (i_valid && i_dirty) ? EVICT : FILL;
                end
        end
        EVICT:
        begin
                if (xfer.done)
                begin
                        xfer.start = 1'b1;      // Fill follows the write-back
                        state_d    = FILL;
                end
        end
        FILL:      if (xfer.done) state_d = UPDATE;
        UPDATE:
        begin
                o_ack   = 1'b1;
                o_wr_en = 1'b1;
                state_d = IDLE;
        end
        UNC_ISSUE: if (xfer.done) state_d = UNC_WAIT;
        UNC_WAIT:
        begin
                o_ack   = 1'b1;
                state_d = IDLE;
        end
        default:   state_d = IDLE;
        endcase
end

// ----------------------------------------
// Transfer command and store write
// ----------------------------------------

assign unc       = (state_q == IDLE) ? i_uncached
                                     : (state_q == UNC_ISSUE || state_q == UNC_WAIT);
assign evict_now = (state_q == IDLE) && i_valid && i_dirty;

assign xfer.single = unc;
assign xfer.write  = unc ? cur_wr : evict_now;
assign xfer.addr   = unc       ? cur_addr
                   : evict_now ? {i_tag, cur_idx, OFF_W'(0)}     // Victim line
                   :             {cur_tag, cur_idx, OFF_W'(0)};
assign xfer.sel    = cur_ben;
assign xfer.wline  = unc ? LINE_W'(cur_din) : i_line;

assign o_index    = cur_idx;
assign o_tag      = cur_tag;
assign o_dirty    = cur_wr;                     // Refill by a read stays clean
assign o_line     = (state_q == UPDATE) ? merged : rep_din;
assign o_line_ben = (state_q == UPDATE) ? '1 : shift_ben;

always_comb
begin
        case (state_q)
        UPDATE:   o_dat = merged[cur_word*word_w +: word_w];
        UNC_WAIT: o_dat = xfer.rline[word_w-1:0];
        default:  o_dat = i_line[cur_word*word_w +: word_w];
        endcase
end

assign o_state = state_q;

endmodule

// ==== hdl/wb_line_master.sv ====
// Wishbone master that runs incrementing line bursts and single classic beats
`timescale 1ns/1ps

module wb_line_master
        import dcache_pkg::*;
#(
        parameter int LINE_BYTES = 16
)
(
        input  logic                i_clk,
        input  logic                i_reset,
        line_xfer_if.master         xfer,
        output logic                o_wb_cyc,
        output logic                o_wb_stb,
        output logic                o_wb_we,
        output logic [word_w-1:0]   o_wb_adr,
        output logic [3:0]          o_wb_sel,
        output logic [word_w-1:0]   o_wb_dat,
        output cti_t                o_wb_cti,
        input  logic                i_wb_ack,
        input  logic [word_w-1:0]   i_wb_dat
);

localparam int WORDS = LINE_BYTES / (word_w / 8);
localparam int CNT_W = $clog2(WORDS);
localparam int OFF_W = $clog2(LINE_BYTES);

logic                   cyc_q, we_q, single_q, done_q, last;
logic [CNT_W-1:0]       cnt_q;                  // Beat within the line
logic [word_w-1:0]      base_q;
logic [3:0]             sel_q;
logic [word_w-1:0]      rbuf [WORDS];

assign last = single_q || (cnt_q == CNT_W'(WORDS - 1));

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                cyc_q    <= 1'b0;
                done_q   <= 1'b0;
                cnt_q    <= '0;
                we_q     <= 1'b0;
                single_q <= 1'b0;
        end
        else
        begin
                done_q <= 1'b0;
                if (xfer.start)
                begin
                        cyc_q    <= 1'b1;
                        cnt_q    <= '0;
                        we_q     <= xfer.write;
                        single_q <= xfer.single;
                end
                else if (cyc_q && i_wb_ack)
                begin
                        if (last)
                        begin
                                cyc_q  <= 1'b0;
                                done_q <= 1'b1;     // Cycle after the final ack
                        end
                        else
                                cnt_q <= cnt_q + 1'b1;
                end
        end
end

// Burst base is forced to the line boundary
always_ff @(posedge i_clk)
begin
        if (xfer.start)
        begin
                base_q <= xfer.single ? xfer.addr
                                      : {xfer.addr[word_w-1:OFF_W], OFF_W'(0)};
                sel_q  <= xfer.sel;
        end
        if (cyc_q && i_wb_ack && !we_q)
                rbuf[cnt_q] <= i_wb_dat;
end

always_comb
begin
        for (int i = 0; i < WORDS; i++)
                xfer.rline[i*word_w +: word_w] = rbuf[i];
end

assign xfer.done = done_q;

assign o_wb_cyc = cyc_q;
assign o_wb_stb = cyc_q;                        // No idle beats inside a burst
assign o_wb_we  = we_q;
assign o_wb_adr = base_q + (word_w'(cnt_q) << 2);
assign o_wb_sel = single_q ? sel_q : 4'hf;
assign o_wb_dat = xfer.wline[cnt_q*word_w +: word_w];
assign o_wb_cti = single_q ? CTI_CLASSIC : (last ? CTI_EOB : CTI_BURST);

endmodule

// ==== hdl/dcache_top.sv ====
// Data cache top level with controller, tag and data store and Wishbone line master
`timescale 1ns/1ps

module dcache_top
        import dcache_pkg::*;
#(
        parameter int CACHE_BYTES = 1024,
        parameter int LINE_BYTES  = 16
)
(
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_rd,
        input  logic        i_wr,
        input  logic        i_uncached,
        input  logic [31:0] i_addr,
        input  logic [31:0] i_din,
        input  logic [3:0]  i_ben,
        output logic        o_ack,
        output logic [31:0] o_dat,
        output logic        o_wb_cyc,
        output logic        o_wb_stb,
        output logic        o_wb_we,
        output logic [31:0] o_wb_adr,
        output logic [3:0]  o_wb_sel,
        output logic [31:0] o_wb_dat,
        output logic [2:0]  o_wb_cti,
        input  logic        i_wb_ack,
        input  logic [31:0] i_wb_dat
);

localparam int IDX_W = $clog2(CACHE_BYTES / LINE_BYTES);
localparam int TAG_W = word_w - $clog2(CACHE_BYTES);

// ----------------------------------------
// Controller to store wiring
// ----------------------------------------
logic [IDX_W-1:0]         st_index;
logic                     st_wr_en, st_wdirty, st_valid, st_rdirty;
logic [TAG_W-1:0]         st_wtag, st_rtag;
logic [LINE_BYTES*8-1:0]  st_wline, st_rline;
logic [LINE_BYTES-1:0]    st_wben;
ctrl_state_t              ctrl_state;           // Named state for waveforms
cti_t                     wb_cti;

line_xfer_if #(.LINE_BYTES(LINE_BYTES)) xfer ();

dcache_ctrl #(.CACHE_BYTES(CACHE_BYTES), .LINE_BYTES(LINE_BYTES)) u_ctrl (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_rd(i_rd), .i_wr(i_wr), .i_uncached(i_uncached),
        .i_addr(i_addr), .i_din(i_din), .i_ben(i_ben),
        .o_ack(o_ack), .o_dat(o_dat), .o_state(ctrl_state),
        .o_index(st_index), .o_wr_en(st_wr_en), .o_tag(st_wtag),
        .o_dirty(st_wdirty), .o_line(st_wline), .o_line_ben(st_wben),
        .i_tag(st_rtag), .i_valid(st_valid), .i_dirty(st_rdirty),
        .i_line(st_rline), .xfer(xfer.ctrl)
);

dcache_store #(.CACHE_BYTES(CACHE_BYTES), .LINE_BYTES(LINE_BYTES)) u_store (
        .i_clk(i_clk), .i_reset(i_reset), .i_index(st_index),
        .i_wr_en(st_wr_en), .i_tag(st_wtag), .i_dirty(st_wdirty),
        .i_line(st_wline), .i_line_ben(st_wben),
        .o_tag(st_rtag), .o_valid(st_valid), .o_dirty(st_rdirty), .o_line(st_rline)
);

wb_line_master #(.LINE_BYTES(LINE_BYTES)) u_master (
        .i_clk(i_clk), .i_reset(i_reset), .xfer(xfer.master),
        .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we),
        .o_wb_adr(o_wb_adr), .o_wb_sel(o_wb_sel), .o_wb_dat(o_wb_dat),
        .o_wb_cti(wb_cti), .i_wb_ack(i_wb_ack), .i_wb_dat(i_wb_dat)
);

assign o_wb_cti = wb_cti;

endmodule

// ==== test/tb_dcache.sv ====
// Testbench for the data cache with Wishbone memory model, stimulus file reader and checks
`timescale 1ns/1ps

module tb_dcache;

localparam int MEM_WORDS = 1024;                // 4 KB behind the bus
localparam int LINES     = 64;

logic        i_clk = 1'b0;
logic        i_reset, i_rd, i_wr, i_uncached;
logic [31:0] i_addr, i_din;
logic [3:0]  i_ben;
logic        o_ack, o_wb_cyc, o_wb_stb, o_wb_we;
logic [31:0] o_dat, o_wb_adr, o_wb_dat;
logic [3:0]  o_wb_sel;
logic [2:0]  o_wb_cti;
logic        i_wb_ack = 1'b0;
logic [31:0] i_wb_dat = '0;

logic [31:0] mem     [MEM_WORDS];               // Bus side contents
logic [31:0] ref_mem [MEM_WORDS];               // What the processor has written
logic [71:0] beats [$];                         // {we, cti, sel, adr, dat} per acked beat
logic [31:0] lfsr_q = 32'hb145_b1f3;
logic [1:0]  waits_q;
logic        sh_valid [LINES];                  // Expected cache state
logic        sh_dirty [LINES];
logic [21:0] sh_tag   [LINES];

dcache_top dut (
        .i_clk(i_clk), .i_reset(i_reset), .i_rd(i_rd), .i_wr(i_wr),
        .i_uncached(i_uncached), .i_addr(i_addr), .i_din(i_din), .i_ben(i_ben),
        .o_ack(o_ack), .o_dat(o_dat), .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb),
        .o_wb_we(o_wb_we), .o_wb_adr(o_wb_adr), .o_wb_sel(o_wb_sel), .o_wb_dat(o_wb_dat),
        .o_wb_cti(o_wb_cti), .i_wb_ack(i_wb_ack), .i_wb_dat(i_wb_dat)
);

always #10 i_clk = ~i_clk;

// ----------------------------------------
// Helpers
// ----------------------------------------

task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
endtask

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
                $display("Error: %s is %h, expected %h", name, got, exp);
                abort_run();
        end
endtask

function logic lfsr_step();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];      // x^32+x^22+x^2+x+1
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
endfunction

function logic [1:0] draw_wait();
        logic [1:0] w;
        w[1] = lfsr_step();
        w[0] = lfsr_step();
        return w;
endfunction

function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] din,
                                            input logic [3:0] ben);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++)
                if (ben[b])
                        res[b*8 +: 8] = din[b*8 +: 8];
        return res;
endfunction

// ----------------------------------------
// Wishbone memory model
// ----------------------------------------

always @(posedge i_clk)
begin
        if (i_reset)
        begin
                i_wb_ack <= 1'b0;
                waits_q  <= 2'd0;
        end
        else if (i_wb_ack && o_wb_stb)          // Beat completes at this edge
        begin
                check_val("o_wb_cyc", {31'd0, o_wb_cyc}, 32'd1);
                beats.push_back({o_wb_we, o_wb_cti, o_wb_sel, o_wb_adr, o_wb_dat});
                if (o_wb_we)
                        mem[o_wb_adr[11:2]] = merge_bytes(mem[o_wb_adr[11:2]], o_wb_dat, o_wb_sel);
                i_wb_ack <= 1'b0;
                waits_q  <= draw_wait();        // Wait cycles before the next ack
        end
        else if (o_wb_stb)
        begin
                if (o_wb_adr[31:12] != '0)
                begin
                        $display("Bus address %h lies outside the memory model", o_wb_adr);
                        abort_run();
                end
                if (waits_q == 2'd0)
                begin
                        i_wb_ack <= 1'b1;
                        i_wb_dat <= mem[o_wb_adr[11:2]];
                end
                else
                        waits_q <= waits_q - 2'd1;
        end
end

// ----------------------------------------
// Expected bus traffic
// ----------------------------------------

task automatic check_beat(input logic [31:0] adr, input logic we, input logic [3:0] sel,
                          input logic [2:0] cti, input logic [31:0] dat, input logic has_dat);
        logic [71:0] b;
        b = beats.pop_front();
        check_val("o_wb_adr", b[63:32], adr);
        check_val("o_wb_we", {31'd0, b[71]}, {31'd0, we});
        check_val("o_wb_cti", {29'd0, b[70:68]}, {29'd0, cti});
        check_val("o_wb_sel", {28'd0, b[67:64]}, {28'd0, sel});
        if (has_dat)
                check_val("o_wb_dat", b[31:0], dat);
endtask

task automatic check_traffic(input logic unc, input logic wr, input logic [31:0] addr,
                             input logic [31:0] din, input logic [3:0] ben);
        logic [5:0]  idx;
        logic [21:0] tag;
        logic [31:0] victim, line;
        logic        hit;
        int          expect_n;
        idx    = addr[9:4];
        tag    = addr[31:10];
        victim = {sh_tag[idx], idx, 4'h0};
        line   = {addr[31:4], 4'h0};
        hit    = sh_valid[idx] && (sh_tag[idx] == tag);
        if (unc)
                expect_n = 1;
        else if (hit)
                expect_n = 0;
        else if (sh_valid[idx] && sh_dirty[idx])
                expect_n = 8;                   // Write-back then refill
        else
                expect_n = 4;
        check_val("bus beat count", beats.size(), expect_n);

        if (unc)
                check_beat(addr, wr, ben, 3'd0, din, wr);
        if (expect_n == 8)
                for (int k = 0; k < 4; k++)
                        check_beat(victim + 32'(4*k), 1'b1, 4'hf, (k == 3) ? 3'd7 : 3'd2,
                                   ref_mem[victim[11:2] + 10'(k)], 1'b1);
        if (!unc && !hit)
                for (int k = 0; k < 4; k++)
                        check_beat(line + 32'(4*k), 1'b0, 4'hf, (k == 3) ? 3'd7 : 3'd2,
                                   32'd0, 1'b0);

        if (!unc)
        begin
                sh_dirty[idx] = (hit && sh_dirty[idx]) || wr;
                sh_valid[idx] = 1'b1;
                sh_tag[idx]   = tag;
        end
        if (wr)
                ref_mem[addr[11:2]] = merge_bytes(ref_mem[addr[11:2]], din, ben);
endtask

// ----------------------------------------
// Stimulus
// ----------------------------------------

task automatic run_op(input logic [15:0] op, input logic [31:0] addr, input logic [31:0] din,
                      input logic [3:0] ben, input logic [31:0] exp);
        logic        is_wr, is_unc, got;
        logic [31:0] rdata;
        is_wr  = (op == "W") || (op == "UW");
        is_unc = (op == "UR") || (op == "UW");
        got    = 1'b0;
        rdata  = '0;
        @(posedge i_clk);
        i_rd       <= !is_wr;
        i_wr       <= is_wr;
        i_uncached <= is_unc;
        i_addr     <= addr;
        i_din      <= din;
        i_ben      <= ben;
        for (int n = 0; n < 200 && !got; n++)
        begin
                @(posedge i_clk);
                if (o_ack)
                begin
                        got   = 1'b1;
                        rdata = o_dat;
                end
        end
        if (!got)
        begin
                $display("No o_ack within 200 cycles for %s at address %h", op, addr);
                abort_run();
        end
        check_val("o_wb_cyc", {31'd0, o_wb_cyc}, 32'd0);    // Bus released by the ack
        i_rd <= 1'b0;                           // Dropped in the cycle after the ack
        i_wr <= 1'b0;
        if (!is_wr)
                check_val("o_dat", rdata, exp);
        check_traffic(is_unc, is_wr, addr, din, ben);
endtask

initial
begin
        int               fd, n, ops;
        logic [15:0]      op;
        logic [31:0]      addr, data, expect_val;
        logic [3:0]       ben;
        logic [8*128-1:0] rest;
        i_reset    = 1'b1;
        i_rd       = 1'b0;
        i_wr       = 1'b0;
        i_uncached = 1'b0;
        i_addr     = '0;
        i_din      = '0;
        i_ben      = '0;
        for (int w = 0; w < MEM_WORDS; w++)
        begin
                mem[w]     = 32'(w) ^ 32'h5a5a_0000;    // Word address marks each word
                ref_mem[w] = mem[w];
        end
        for (int i = 0; i < LINES; i++)
        begin
                sh_valid[i] = 1'b0;
                sh_dirty[i] = 1'b0;
                sh_tag[i]   = '0;
        end
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;

        fd = $fopen("test/dcache_stim.txt", "r");
        if (fd == 0)
        begin
                $display("Cannot open the stimulus file test/dcache_stim.txt");
                abort_run();
        end
        ops = 0;
        while ($fscanf(fd, "%s", op) == 1)
        begin
                if (op == "#")
                        n = $fgets(rest, fd);   // Skip the comment text
                else if (op != "R" && op != "W" && op != "UR" && op != "UW")
                begin
                        $display("Unknown operation %s in the stimulus file", op);
                        abort_run();
                end
                else
                begin
                        n = $fscanf(fd, "%h %h %h %h", addr, data, ben, expect_val);
                        if (n != 4)
                        begin
                                $display("Stimulus line for %s has missing fields", op);
                                abort_run();
                        end
                        run_op(op, addr, data, ben, expect_val);
                        ops++;
                end
        end
        $fclose(fd);

        repeat (4) @(posedge i_clk);
        check_val("stray bus beats", beats.size(), 0);
        if (ops == 0)
        begin
                $display("The stimulus file held no operations");
                abort_run();
        end
        else
        begin
                $display("*** TEST PASSED ***");
                $finish;
        end
end

endmodule

// ==== test/dcache_stim.txt ====
# Cache operations, all fields hex; expect is checked on R and UR only
# op  addr      data      ben  expect
R     00000100  00000000  f    5a5a0040
R     00000100  00000000  f    5a5a0040
W     00000104  11223344  3    00000000
R     00000104  00000000  f    5a5a3344
R     00000108  00000000  f    5a5a0042
W     00000208  aabbccdd  c    00000000
R     00000208  00000000  f    aabb0082
R     0000020c  00000000  f    5a5a0083
R     00000504  00000000  f    5a5a0141
UR    00000104  00000000  f    5a5a3344
W     0000050c  99887766  f    00000000
R     00000108  00000000  f    5a5a0042
UR    0000050c  00000000  f    99887766
UW    00000300  deadbeef  6    00000000
UR    00000300  00000000  f    5aadbec0
R     00000208  00000000  f    aabb0082
R     00000104  00000000  f    5a5a3344
W     00000608  0badf00d  f    00000000
R     00000608  00000000  f    0badf00d
UR    00000208  00000000  f    aabb0082
R     0000060c  00000000  f    5a5a0183

// ==== compile.f ====
hdl/dcache_pkg.sv
hdl/line_xfer_if.sv
hdl/dcache_store.sv
hdl/dcache_ctrl.sv
hdl/wb_line_master.sv
hdl/dcache_top.sv
test/tb_dcache.sv

// ==== Makefile ====
TOP = tb_dcache

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and look for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary -j 0 -Wno-fatal --top-module $(TOP) -f compile.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
